//--- aes_enc.f
verilog/aes_pkg.sv
verilog/aes_sbox_word.sv
verilog/aes_key_schedule.sv
verilog/aes_round_core.sv
verilog/aes_out_stage.sv
verilog/aes_enc_top.sv
tb/aes_enc_props.sv
tb/aes_enc_tb.sv

//--- run.sh
#!/bin/sh
# build the AES-128 encipher testbench with Verilator and run it
# exit status is 0 only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 \
    --top-module aes_enc_tb -f aes_enc.f -o aes_enc_sim \
    && ./obj_dir/aes_enc_sim +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -q "Testbench passed" \
    && exit 0 \
    || exit 1

//--- tb/aes_enc_props.sv
// concurrent checks bound to the encipher top level
// reset idle, fixed latency, output hold, back-pressure on in_ready

`timescale 1ns/1ps
`default_nettype none

module aes_enc_props (
    input logic            clk,
    input logic            rst,
    input logic            in_valid,
    input logic            in_ready,
    input logic            out_valid,
    input aes_pkg::block_t out_block,
    input logic            out_ready,
    input logic            res_valid   // core result waiting in ST_DONE
);

    localparam logic [5:0] LAT = 6'd51; // accept edge to output stage load

    logic       started;   // first in_valid seen
    logic [5:0] age;       // cycles since accept, 0 when none
    logic       ready_ok;  // out_ready high all through the window

    int fail_idle = 0;
    int fail_lat  = 0;
    int fail_hold = 0;
    int fail_busy = 0;
    int fail_cnt;          // read by the testbench

    assign fail_cnt = fail_idle + fail_lat + fail_hold + fail_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            started  <= 1'b0;
            age      <= '0;
            ready_ok <= 1'b0;
        end else begin
            if (in_valid)
                started <= 1'b1;
            if (in_valid && in_ready) begin
                age      <= 6'd1;                       // window opens
                ready_ok <= 1'b1;
            end else if (age != '0) begin
                age      <= (age == LAT) ? 6'd0 : age + 6'd1;
                ready_ok <= ready_ok && out_ready;      // any stall spoils it
            end
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (rst)
        !started |-> in_ready && !out_valid)
        else begin
            $error("in_ready low or out_valid high before the first input");
            fail_idle = fail_idle + 1;
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        (age == LAT && ready_ok) |=> $rose(out_valid) && in_ready)
        else begin
            $error("out_valid did not rise or in_ready low 51 cycles after accept");
            fail_lat = fail_lat + 1;
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_block))
        else begin
            $error("output changed while waiting for out_ready");
            fail_hold = fail_hold + 1;
        end

    a_busy: assert property (@(posedge clk) disable iff (rst)
        res_valid && out_valid && !out_ready |=> !in_ready)
        else begin
            $error("core went idle while the output stage was full and stalled");
            fail_busy = fail_busy + 1;
        end

endmodule

`default_nettype wire

//--- tb/aes_enc_tb.sv
// AES-128 encipher testbench: clock, reset, known-answer stimulus
// expected-ciphertext queue, output monitor, per-test report

`timescale 1ns/1ps
`default_nettype none

module aes_enc_tb;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 4;
    localparam int          LATENCY      = 51;  // accept edge to out_valid
    localparam int          RAND_BLOCKS  = 30;
    localparam int          NUM_XFERS    = 3 + 1 + 3 + RAND_BLOCKS;
    localparam int          XFER_CYCLES  = 60;  // one block plus some stall
    localparam int          TIMEOUT      = 2 * NUM_XFERS * XFER_CYCLES + RESET_CYCLES;
    localparam logic [31:0] SEED         = 32'he91ecbb5;

    localparam logic [1:0] RDY_HIGH   = 2'd0;
    localparam logic [1:0] RDY_LOW    = 2'd1;
    localparam logic [1:0] RDY_RANDOM = 2'd2;

    // FIPS 197 appendix B, appendix C.1, all-zero
    localparam aes_pkg::block_t KAT_KEY [3] = '{
        128'h2b7e151628aed2a6abf7158809cf4f3c,
        128'h000102030405060708090a0b0c0d0e0f,
        128'h00000000000000000000000000000000
    };
    localparam aes_pkg::block_t KAT_PT [3] = '{
        128'h3243f6a8885a308d313198a2e0370734,
        128'h00112233445566778899aabbccddeeff,
        128'h00000000000000000000000000000000
    };
    localparam aes_pkg::block_t KAT_CT [3] = '{
        128'h3925841d02dc09fbdc118597196a0b32,
        128'h69c4e0d86a7b0430d8cdb78070b4c55a,
        128'h66e94bd4ef8a2c3b884cfa59ca342b2e
    };

    logic             clk = 1'b0;
    logic             rst;
    logic             in_valid;
    aes_pkg::aes_in_t in_data;
    logic             in_ready;
    logic             out_valid;
    aes_pkg::block_t  out_block;
    logic             out_ready = 1'b1;

    logic [1:0]      ready_mode = RDY_HIGH;  // out_ready pattern
    logic [31:0]     rng_stim   = SEED;      // gaps and vector choice
    logic [31:0]     rng_ready  = ~SEED;     // out_ready stalls
    aes_pkg::block_t exp_next;               // ciphertext of the block on in_data
    aes_pkg::block_t exp_q [$];              // in accept order

    int cycle_cnt  = 0;
    int sent_cnt   = 0;  // driver side
    int acc_cnt    = 0;  // seen by monitor
    int recv_cnt   = 0;
    int seq_errors = 0;
    int mon_errors = 0;
    int seq_checks = 0;
    int mon_checks = 0;
    int tests_run  = 0;
    int tests_ok   = 0;
    int errs_before;

    always #(CLK_PERIOD / 2) clk = ~clk;

    aes_enc_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_block (out_block),
        .out_ready (out_ready)
    );

    bind aes_enc_top aes_enc_props u_props (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_block (out_block),
        .out_ready (out_ready),
        .res_valid (res_valid)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        lcg = s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int error_count();
        error_count = seq_errors + mon_errors + dut0.u_props.fail_cnt;
    endfunction

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("ERROR: run stopped after %0d cycles, %0d of %0d blocks delivered",
                     cycle_cnt, recv_cnt, sent_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (ready_mode == RDY_RANDOM) begin
            rng_ready = lcg(rng_ready);
            out_ready <= (rng_ready[31:30] != 2'b00); // stall about 1 in 4
        end else begin
            out_ready <= (ready_mode == RDY_HIGH);
        end
    end

    // scoreboard, sees pre-edge values
    always @(posedge clk) begin : monitor
        aes_pkg::block_t exp_blk;
        if (!rst) begin
            if (out_valid && out_ready) begin
                recv_cnt <= recv_cnt + 1;
                if (exp_q.size() == 0) begin
                    $display("ERROR: ciphertext %h delivered with no block outstanding",
                             out_block);
                    mon_errors <= mon_errors + 1;
                end else begin
                    exp_blk    = exp_q.pop_front();
                    mon_checks <= mon_checks + 1;
                    assert (out_block == exp_blk)
                    else begin
                        $display("FAILED out_block: got %h expected %h", out_block, exp_blk);
                        mon_errors <= mon_errors + 1;
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(exp_next);  // pop above takes older entries first
                acc_cnt <= acc_cnt + 1;
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        seq_checks++;
        assert (got == exp)
        else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            seq_errors++;
        end
    endtask

    task automatic next_rand(output logic [31:0] r);
        rng_stim = lcg(rng_stim);
        r        = rng_stim;
    endtask

    // called just after a rising edge, returns on the accepting edge
    task automatic send_block(input int idx);
        in_data.key   <= KAT_KEY[idx];
        in_data.block <= KAT_PT[idx];
        exp_next      <= KAT_CT[idx];
        in_valid      <= 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        in_valid <= 1'b0;
        sent_cnt++;
    endtask

    task automatic wait_drain();
        @(posedge clk);  // monitor counts are one edge behind
        while (recv_cnt != acc_cnt) begin
            @(posedge clk);
        end
    endtask

    task automatic begin_test();
        errs_before = error_count();
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count() - errs_before;
        tests_run++;
        if (errs == 0) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errs);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          lat;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        exp_next = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        begin_test();
        repeat (6) begin
            @(posedge clk);
            check_val("in_ready", in_ready, 1);
            check_val("out_valid", out_valid, 0);
        end
        end_test("reset idle");

        begin_test();
        for (int i = 0; i < 3; i++) begin
            send_block(i);                    // back to back
        end
        wait_drain();
        end_test("known answers");

        begin_test();
        send_block(0);
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!out_valid);
        check_val("latency", lat - 1, LATENCY);  // value read predates this edge
        check_val("in_ready", in_ready, 1);  // core free in same cycle
        wait_drain();
        end_test("latency");

        begin_test();
        ready_mode <= RDY_LOW;
        send_block(0);                        // ends up in output stage
        send_block(1);                        // ends up waiting in the core
        repeat (LATENCY + 4) @(posedge clk);
        repeat (8) begin
            @(posedge clk);
            check_val("in_ready", in_ready, 0);
            check_val("out_valid", out_valid, 1);
        end
        ready_mode <= RDY_RANDOM;
        send_block(2);
        wait_drain();
        end_test("output stall");

        begin_test();
        ready_mode <= RDY_RANDOM;
        for (int n = 0; n < RAND_BLOCKS; n++) begin
            next_rand(r);
            repeat (int'(r[9:8])) @(posedge clk);  // gap of 0 to 3 cycles
            send_block(int'(r[31:16]) % 3);
        end
        wait_drain();
        ready_mode <= RDY_HIGH;
        check_val("blocks left in queue", exp_q.size(), 0);
        end_test("random order");

        repeat (2) @(posedge clk);
        $display("tests %0d, ok %0d, checks %0d, errors %0d",
                 tests_run, tests_ok, seq_checks + mon_checks, error_count());
        if (error_count() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/aes_enc_top.sv
// AES-128 encipher top level
// round core, key schedule and output holding stage

`timescale 1ns/1ps
`default_nettype none

module aes_enc_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  aes_pkg::aes_in_t in_data,   // key and plaintext
    output logic             in_ready,
    output logic             out_valid,
    output aes_pkg::block_t  out_block, // ciphertext
    input  logic             out_ready
);

    logic            key_load;
    logic            key_step;
    aes_pkg::block_t round_key;
    logic            res_valid;
    logic            res_ready;
    aes_pkg::block_t res_block;

    aes_round_core u_core (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .key_load  (key_load),
        .key_step  (key_step),
        .round_key (round_key),
        .res_valid (res_valid),
        .res_block (res_block),
        .res_ready (res_ready)
    );

    aes_key_schedule u_keys (
        .clk       (clk),
        .rst       (rst),
        .key_load  (key_load),
        .key_in    (in_data.key),  // sampled on the accept edge
        .key_step  (key_step),
        .round_key (round_key)
    );

    aes_out_stage u_out (
        .clk       (clk),
        .rst       (rst),
        .res_valid (res_valid),
        .res_block (res_block),
        .res_ready (res_ready),
        .out_valid (out_valid),
        .out_block (out_block),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- verilog/aes_key_schedule.sv
// AES-128 round-key register and rcon register
// next key formed from the rotated, substituted last word

`timescale 1ns/1ps
`default_nettype none

module aes_key_schedule (
    input  logic            clk,
    input  logic            rst,
    input  logic            key_load,  // accept edge, take key_in
    input  aes_pkg::block_t key_in,
    input  logic            key_step,  // advance to next round key
    output aes_pkg::block_t round_key
);

    aes_pkg::block_t key_q;  // current round key
    aes_pkg::byte_t  rcon_q; // current round constant

    aes_pkg::word_t rot_word; // RotWord of last key word
    aes_pkg::word_t sub_word; // SubWord of the rotated word
    aes_pkg::word_t temp;     // g() result
    aes_pkg::word_t w0, w1, w2, w3;

    assign rot_word = {key_q[23:0], key_q[31:24]}; // bytes left by one

    aes_sbox_word u_sbox (
        .word_in  (rot_word),
        .word_out (sub_word)
    );

    always_comb begin
        temp = sub_word ^ {rcon_q, 24'h000000}; // rcon only in top byte
        w0   = key_q[127:96] ^ temp;
        w1   = key_q[95:64] ^ w0;                // chained through the words
        w2   = key_q[63:32] ^ w1;
        w3   = key_q[31:0] ^ w2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            key_q  <= '0;
            rcon_q <= '0;
        end else if (key_load) begin
            key_q  <= key_in;              // round 0 key is the cipher key
            rcon_q <= aes_pkg::RCON_INIT;
        end else if (key_step) begin
            key_q  <= {w0, w1, w2, w3};
            rcon_q <= aes_pkg::xtime(rcon_q); // 01 02 04 .. 1b 36
        end
    end

    assign round_key = key_q;

endmodule

`default_nettype wire

//--- verilog/aes_out_stage.sv
// one-entry ciphertext holding register with valid/ready on both sides

`timescale 1ns/1ps
`default_nettype none

module aes_out_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            res_valid,
    input  aes_pkg::block_t res_block,
    output logic            res_ready,
    output logic            out_valid,  // doubles as the full flag
    output aes_pkg::block_t out_block,
    input  logic            out_ready
);

    logic load;

    // free now, or emptying on this edge
    assign res_ready = !out_valid || out_ready;
    assign load      = res_valid && res_ready;

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else if (load)
            out_valid <= 1'b1;   // refill, possibly same edge as drain
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load)
            out_block <= res_block; // held stable until taken
    end

endmodule

`default_nettype wire

//--- verilog/aes_pkg.sv
// AES-128 shared types, constants and round-state enum
// pure GF(2^8) helpers: xtime, S-box generation, shift rows, mix columns

`default_nettype none

package aes_pkg;

    typedef logic [7:0]   byte_t;  // one state byte
    typedef logic [31:0]  word_t;  // one column or key word
    typedef logic [127:0] block_t; // column 0 in [127:96]

    typedef struct packed {
        block_t key;   // cipher key, upper half
        block_t block; // plaintext, lower half
    } aes_in_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0, // waiting for a block
        ST_SUB  = 2'd1, // one column through the S-box per cycle
        ST_MIX  = 2'd2, // shift rows, mix columns, add round key
        ST_DONE = 2'd3  // result held for the output stage
    } round_state_e;

    localparam logic [3:0] NUM_ROUNDS = 4'd10;
    localparam int         NUM_COLS   = 4;
    localparam byte_t      RCON_INIT  = 8'h01;
    localparam byte_t      AES_POLY   = 8'h1B; // x^8 = x^4 + x^3 + x + 1

    // multiply by x modulo the AES polynomial
    function automatic byte_t xtime(input byte_t x);
        xtime = {x[6:0], 1'b0} ^ (AES_POLY & {8{x[7]}});
    endfunction

    // multiplicative inverse as x^254, then the affine map
    function automatic byte_t sbox_calc(input byte_t x);
        byte_t p;   // running power of x
        byte_t acc; // product accumulator
        byte_t a;   // shifted multiplicand
        p = 8'h01;
        for (int n = 0; n < 254; n++) begin
            acc = 8'h00;
            a   = p;
            for (int i = 0; i < 8; i++) begin
                if (x[i])
                    acc = acc ^ a; // add partial product
                a = xtime(a);
            end
            p = acc;
        end
        // 0 maps to 0 since 0^254 is 0
        sbox_calc = p ^ {p[6:0], p[7]} ^ {p[5:0], p[7:6]} ^ {p[4:0], p[7:5]}
                    ^ {p[3:0], p[7:4]} ^ 8'h63;
    endfunction

    // row r rotated left by r columns
    function automatic block_t shift_rows(input block_t s);
        shift_rows = '0;
        for (int c = 0; c < NUM_COLS; c++) begin
            for (int r = 0; r < 4; r++) begin
                shift_rows[127 - 8 * (4 * c + r) -: 8] =
                    s[127 - 8 * (4 * ((c + r) % NUM_COLS) + r) -: 8];
            end
        end
    endfunction

    // each column times the fixed matrix {02 03 01 01}
    function automatic block_t mix_columns(input block_t s);
        byte_t b0, b1, b2, b3;
        mix_columns = '0;
        for (int c = 0; c < NUM_COLS; c++) begin
            {b0, b1, b2, b3} = s[127 - 32 * c -: 32];
            mix_columns[127 - 32 * c -: 32] = {
                xtime(b0) ^ xtime(b1) ^ b1 ^ b2 ^ b3,
                b0 ^ xtime(b1) ^ xtime(b2) ^ b2 ^ b3,
                b0 ^ b1 ^ xtime(b2) ^ xtime(b3) ^ b3,
                xtime(b0) ^ b0 ^ b1 ^ b2 ^ xtime(b3)
            };
        end
    endfunction

endpackage

`default_nettype wire

//--- verilog/aes_round_core.sv
// iterative AES-128 round engine, one column through the S-box per cycle
// five cycles per round, ten rounds, result held until taken

`timescale 1ns/1ps
`default_nettype none

module aes_round_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  aes_pkg::aes_in_t in_data,
    output logic             in_ready,
    output logic             key_load,  // load key schedule this edge
    output logic             key_step,  // next round key this edge
    input  aes_pkg::block_t  round_key,
    output logic             res_valid,
    output aes_pkg::block_t  res_block,
    input  logic             res_ready
);

    aes_pkg::round_state_e state_q;
    aes_pkg::block_t       blk_q;    // cipher state, no reset
    logic [1:0]            col_q;    // column under substitution
    logic [3:0]            round_q;  // 1..10

    int              col_base;       // lsb of selected column
    aes_pkg::word_t  sub_in;
    aes_pkg::word_t  sub_out;
    aes_pkg::block_t sr_blk;         // after shift rows
    aes_pkg::block_t mc_blk;         // after mix columns
    logic            last_round;
    logic            accept;

    assign accept     = in_valid && in_ready;
    assign last_round = (round_q == aes_pkg::NUM_ROUNDS);

    // column 0 sits in the top word
    always_comb begin
        col_base = (aes_pkg::NUM_COLS - 1 - int'(col_q)) * 32;
        sub_in   = blk_q[col_base +: 32];
    end

    aes_sbox_word u_sbox (
        .word_in  (sub_in),
        .word_out (sub_out)
    );

    always_comb begin
        sr_blk = aes_pkg::shift_rows(blk_q);
        mc_blk = aes_pkg::mix_columns(sr_blk);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= aes_pkg::ST_IDLE;
            col_q   <= '0;
            round_q <= '0;
        end else begin
            case (state_q)
                aes_pkg::ST_IDLE: begin
                    if (accept) begin
                        state_q <= aes_pkg::ST_SUB;
                        col_q   <= '0;
                        round_q <= 4'd1;
                    end
                end
                aes_pkg::ST_SUB: begin
                    col_q <= col_q + 2'd1;       // wraps to 0 after col 3
                    if (col_q == 2'd3)
                        state_q <= aes_pkg::ST_MIX;
                end
                aes_pkg::ST_MIX: begin
                    if (last_round) begin
                        state_q <= aes_pkg::ST_DONE;
                    end else begin
                        state_q <= aes_pkg::ST_SUB;
                        col_q   <= '0;
                        round_q <= round_q + 4'd1;
                    end
                end
                aes_pkg::ST_DONE: begin
                    if (res_ready)
                        state_q <= aes_pkg::ST_IDLE; // handed to output stage
                end
                default: state_q <= aes_pkg::ST_IDLE;
            endcase
        end
    end

    // datapath writes follow the FSM state
    always_ff @(posedge clk) begin
        if (accept)
            blk_q <= in_data.block ^ in_data.key; // initial add round key
        else if (state_q == aes_pkg::ST_SUB)
            blk_q[col_base +: 32] <= sub_out;
        else if (state_q == aes_pkg::ST_MIX)
            blk_q <= (last_round ? sr_blk : mc_blk) ^ round_key; // no mix in round 10
    end

    assign in_ready  = (state_q == aes_pkg::ST_IDLE);
    assign key_load  = accept;
    assign key_step  = (state_q == aes_pkg::ST_SUB) && (col_q == 2'd0); // once per round
    assign res_valid = (state_q == aes_pkg::ST_DONE);
    assign res_block = blk_q;

endmodule

`default_nettype wire

//--- verilog/aes_sbox_word.sv
// four parallel S-box lookups on one 32-bit word
// table filled once at initialization from the package generator

`timescale 1ns/1ps
`default_nettype none

module aes_sbox_word (
    input  aes_pkg::word_t word_in,  // four bytes to substitute
    output aes_pkg::word_t word_out  // substituted bytes, same order
);

    aes_pkg::byte_t sbox_tbl [0:255]; // ROM contents

    initial begin
        for (int i = 0; i < 256; i++) begin
            sbox_tbl[i] = aes_pkg::sbox_calc(aes_pkg::byte_t'(i)); // computed once
        end
    end

    // byte lanes are independent, no ordering between them
    genvar b;
    generate
        for (b = 0; b < 4; b++) begin : g_lane
            assign word_out[8 * b +: 8] = sbox_tbl[word_in[8 * b +: 8]];
        end
    endgenerate

endmodule

`default_nettype wire
